//--- include/mul_cfg.svh
/*
  multiplier configuration
  operand width, Booth digit count and bits retired per step
*/
`ifndef MUL_CFG_SVH
`define MUL_CFG_SVH

// one machine word per operand
`define MUL_WIDTH 32

// magnitude is zero-extended to 34 bits so an unsigned top bit recodes right,
// which gives 17 radix-4 digits
`define MUL_STEPS 17

// bits retired by each Booth step
`define BOOTH_BITS 2

`endif

//--- rtl/mul_pkg.sv
/*
  multiplier types
  operand, product, Booth digit, request and operand info structs
*/
`include "mul_cfg.svh"

package mul_pkg;

  // one signed or unsigned word
  typedef logic [`MUL_WIDTH-1:0] oprd_t;

  // full double-word product
  typedef logic [2*`MUL_WIDTH-1:0] prod_t;

  // radix-4 digit, zero when neither one nor two is set
  typedef struct packed {
    logic one;
    logic two;
    logic neg;
  } booth_t;

  typedef struct packed {
    oprd_t a;
    oprd_t b;
  } mul_req_t;

  // unsigned magnitudes plus the sign the product must carry
  typedef struct packed {
    oprd_t mag_a;
    oprd_t mag_b;
    logic  out_sign;
  } oprd_info_t;

endpackage

//--- rtl/booth_recoder.sv
/*
  radix-4 Booth recoder
  maps a multiplier bit pair and the bit below it to a digit in -2..+2
*/
`timescale 1ns/1ps
`include "mul_cfg.svh"

module booth_recoder (
  input  logic [`BOOTH_BITS:0] bits,
  output mul_pkg::booth_t      digit
);

  // bits = {pair, previous bit}
  always_comb begin
    digit = '0;
    case (bits)
      3'b001,
      3'b010: begin
        digit.one = 1'b1;
      end
      3'b011: begin
        digit.two = 1'b1;
      end
      3'b100: begin
        digit.two = 1'b1;
        digit.neg = 1'b1;
      end
      3'b101,
      3'b110: begin
        digit.one = 1'b1;
        digit.neg = 1'b1;
      end
      // 000 and 111 both add nothing
      default: begin
        digit = '0;
      end
    endcase
  end

endmodule

//--- rtl/oprd_sign.sv
/*
  operand complementor and sign bit
  captures both operand magnitudes and the product sign on load
*/
`timescale 1ns/1ps
`include "mul_cfg.svh"

module oprd_sign (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load,
  input  mul_pkg::mul_req_t   operands,
  output mul_pkg::oprd_info_t info
);
  import mul_pkg::*;

  oprd_t mag_a;
  oprd_t mag_b;
  logic  sign_a;
  logic  sign_b;

  // two's complement when the top bit is set
  // the most negative value maps onto itself and reads as 2**(w-1) unsigned
  function automatic oprd_t magnitude(oprd_t v);
    oprd_t inv_inc;
    inv_inc = ~v + 1'b1;
    return v[`MUL_WIDTH-1] ? inv_inc : v;
  endfunction

  assign sign_a = operands.a[`MUL_WIDTH-1];
  assign sign_b = operands.b[`MUL_WIDTH-1];
  assign mag_a  = magnitude(operands.a);
  assign mag_b  = magnitude(operands.b);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      info <= '0;
    end else if (load) begin
      info.mag_a    <= mag_a;
      info.mag_b    <= mag_b;
      info.out_sign <= sign_a ^ sign_b;
    end
  end

endmodule

//--- rtl/zero_det.sv
/*
  operand zero detect
  flags a zero in either operand so control can skip the iteration
*/
`timescale 1ns/1ps

module zero_det (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              load,
  input  mul_pkg::mul_req_t operands,
  output logic              any_zero
);

  logic a_is0;
  logic b_is0;

  // a zero flag per operand
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a_is0 <= 1'b0;
      b_is0 <= 1'b0;
    end else if (load) begin
      a_is0 <= (operands.a == '0);
      b_is0 <= (operands.b == '0);
    end
  end

  assign any_zero = a_is0 | b_is0;

endmodule

//--- rtl/booth_accum.sv
/*
  Booth accumulator
  adds one radix-4 multiple of mag_a per step, shifts the partial product
  right two bits and applies the output sign when finished
*/
`timescale 1ns/1ps
`include "mul_cfg.svh"

module booth_accum (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load,
  input  logic                step,
  input  logic                clr_prod,
  input  logic                finish,
  input  mul_pkg::oprd_info_t info,
  output mul_pkg::prod_t      result
);
  import mul_pkg::*;

  // two guard bits keep the running sum of +-2*mag_a from overflowing
  localparam int ACC_W  = `MUL_WIDTH + 2;
  localparam int MPLR_W = `MUL_STEPS * `BOOTH_BITS;

  logic signed [ACC_W-1:0]  sum;
  logic signed [ACC_W-1:0]  sum_nxt;
  logic signed [ACC_W-1:0]  addend;
  logic [ACC_W-1:0]         mag_ext;
  logic [ACC_W-1:0]         multiple;
  logic [MPLR_W-1:0]        mplr;
  logic [ACC_W+MPLR_W-1:0]  full;
  logic                     prev;
  logic                     load_q;
  booth_t                   digit;
  prod_t                    prod_mag;

  booth_recoder u_recoder (
    .bits  ({mplr[`BOOTH_BITS-1:0], prev}),
    .digit (digit)
  );

  // select 0, A or 2A, then negate for the upper half of the table
  always_comb begin
    mag_ext = ACC_W'(info.mag_a);
    if (digit.two) begin
      multiple = mag_ext << 1;
    end else if (digit.one) begin
      multiple = mag_ext;
    end else begin
      multiple = '0;
    end
    addend  = digit.neg ? -multiple : multiple;
    sum_nxt = sum + addend;
  end

  // the multiplier register doubles as the low half of the product
  assign full     = {sum, mplr};
  assign prod_mag = full[2*`MUL_WIDTH-1:0];

  // magnitudes land one cycle after load, so start from the delayed strobe
  always_ff @(posedge clk) begin
    if (load_q) begin
      sum  <= '0;
      mplr <= MPLR_W'(info.mag_b);
      prev <= 1'b0;
    end else if (step) begin
      // arithmetic funnel shift of {sum, mplr} by two
      sum  <= {{`BOOTH_BITS{sum_nxt[ACC_W-1]}}, sum_nxt[ACC_W-1:`BOOTH_BITS]};
      mplr <= {sum_nxt[`BOOTH_BITS-1:0], mplr[MPLR_W-1:`BOOTH_BITS]};
      prev <= mplr[`BOOTH_BITS-1];
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      load_q <= 1'b0;
      result <= '0;
    end else begin
      load_q <= load;
      if (finish) begin
        if (clr_prod) begin
          result <= '0;
        end else if (info.out_sign) begin
          result <= -prod_mag;
        end else begin
          result <= prod_mag;
        end
      end
    end
  end

endmodule

//--- rtl/mul_ctrl.sv
/*
  multiplier control
  four-phase req/ack FSM with early exit on zero and a Booth step counter
*/
`timescale 1ns/1ps
`include "mul_cfg.svh"

module mul_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic req,
  input  logic any_zero,
  output logic load,
  output logic step,
  output logic clr_prod,
  output logic finish,
  output logic ack
);

  localparam int CNT_W = $clog2(`MUL_STEPS);

  typedef enum logic [2:0] {
    st_idle,
    st_check,
    st_iterate,
    st_finish,
    st_ack_hi
  } state_t;

  state_t           state;
  state_t           state_nxt;
  logic [CNT_W-1:0] cnt;
  logic             last_step;

  assign last_step = (cnt == CNT_W'(`MUL_STEPS - 1));

  always_comb begin
    state_nxt = state;
    case (state)
      st_idle:    if (req) state_nxt = st_check;
      // zero operand jumps straight to the result
      st_check:   state_nxt = any_zero ? st_ack_hi : st_iterate;
      st_iterate: if (last_step) state_nxt = st_finish;
      st_finish:  state_nxt = st_ack_hi;
      // hold ack until the requester lets go
      st_ack_hi:  if (!req) state_nxt = st_idle;
      default:    state_nxt = st_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_idle;
      cnt   <= '0;
    end else begin
      state <= state_nxt;
      if (state == st_iterate) begin
        cnt <= last_step ? '0 : cnt + 1'b1;
      end
    end
  end

  assign load     = (state == st_idle) && req;
  assign step     = (state == st_iterate);
  assign clr_prod = (state == st_check) && any_zero;
  assign finish   = (state == st_finish) || clr_prod;
  assign ack      = (state == st_ack_hi);

endmodule

//--- rtl/mul_top.sv
/*
  sequential signed 32x32 multiplier
  radix-4 Booth datapath behind a four-phase req/ack handshake
*/
`timescale 1ns/1ps

module mul_top (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              req,
  input  mul_pkg::mul_req_t operands,
  output logic              ack,
  output mul_pkg::prod_t    result
);
  import mul_pkg::*;

  logic       load;
  logic       step;
  logic       clr_prod;
  logic       finish;
  logic       any_zero;
  oprd_info_t info;

  mul_ctrl u_ctrl (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .any_zero (any_zero),
    .load     (load),
    .step     (step),
    .clr_prod (clr_prod),
    .finish   (finish),
    .ack      (ack)
  );

  // both capture units sample the request on the same load strobe
  oprd_sign u_oprd_sign (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (load),
    .operands (operands),
    .info     (info)
  );

  zero_det u_zero_det (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (load),
    .operands (operands),
    .any_zero (any_zero)
  );

  booth_accum u_accum (
    .clk      (clk),
    .rst_n    (rst_n),
    .load     (load),
    .step     (step),
    .clr_prod (clr_prod),
    .finish   (finish),
    .info     (info),
    .result   (result)
  );

endmodule

//--- verif/mul_tb.sv
/*
  multiplier testbench
  random and corner operand pairs through the req/ack handshake,
  checked against a signed product model
*/
`timescale 1ns/1ps
`include "mul_cfg.svh"

module mul_tb;
  import mul_pkg::*;

  localparam int RESET_CYCLES = 3;
  localparam int NUM_RANDOM   = 200;
  localparam int NUM_CORNER   = 16;
  localparam int NUM_ZERO     = 6;
  localparam int NUM_TXNS     = NUM_RANDOM + NUM_CORNER + NUM_ZERO;
  // 20 cycles of latency, up to 7 held cycles, the release and one idle cycle fit in 30
  localparam int CYCLE_LIMIT  = NUM_TXNS * 30 + RESET_CYCLES;

  logic        clk;
  logic        rst_n;
  logic        req;
  mul_req_t    operands;
  logic        ack;
  prod_t       result;

  logic [31:0] rng_state;
  int          cycles;
  int          checks;
  int          value_errors;
  int          proto_errors;
  logic        ack_prev;
  oprd_t       corners [0:3];

  mul_top dut (
    .clk      (clk),
    .rst_n    (rst_n),
    .req      (req),
    .operands (operands),
    .ack      (ack),
    .result   (result)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // low LCG bits are weak, so build a word from two upper halves
  function automatic oprd_t rand_word();
    logic [31:0] r1;
    logic [31:0] r2;
    r1 = next_rand();
    r2 = next_rand();
    return {r1[31:16], r2[31:16]};
  endfunction

  function automatic prod_t ref_product(input oprd_t a, input oprd_t b);
    logic signed [2*`MUL_WIDTH-1:0] sa;
    logic signed [2*`MUL_WIDTH-1:0] sb;
    sa = {{`MUL_WIDTH{a[`MUL_WIDTH-1]}}, a};
    sb = {{`MUL_WIDTH{b[`MUL_WIDTH-1]}}, b};
    return sa * sb;
  endfunction

  // sample and drive 2 ns after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic run_mul(input string name, input oprd_t a, input oprd_t b,
                         output int latency);
    prod_t       expected;
    prod_t       held;
    logic [31:0] r;
    int          extra;
    expected   = ref_product(a, b);
    r          = next_rand();
    extra      = r[31:29];
    operands.a = a;
    operands.b = b;
    req        = 1'b1;
    latency    = 0;
    do begin
      next_cycle();
      latency++;
    end while (!ack);
    checks++;
    assert (result === expected) else begin
      value_errors++;
      $display("FAIL %s: expected %h, actual %h", name, expected, result);
    end
    held = result;
    // requester stalls with req still high
    repeat (extra) begin
      next_cycle();
      assert (ack === 1'b1 && result === held) else begin
        proto_errors++;
        $display("%s: ack or result changed while req was held high", name);
      end
    end
    req        = 1'b0;
    operands.a = rand_word();
    operands.b = rand_word();
    next_cycle();
    assert (ack === 1'b0) else begin
      proto_errors++;
      $display("%s: ack still high one cycle after req was dropped", name);
    end
    // idle cycle with req low before the next request
    next_cycle();
  endtask

  // handshake order on every edge
  always begin
    @(posedge clk);
    #1;
    if (rst_n) begin
      if (ack && !ack_prev) begin
        assert (req) else begin
          proto_errors++;
          $display("ack rose while req was low");
        end
      end
      if (!ack && ack_prev) begin
        assert (!req) else begin
          proto_errors++;
          $display("ack fell while req was still high");
        end
      end
    end
    ack_prev = ack;
  end

  initial begin
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run did not complete within %0d cycles", CYCLE_LIMIT);
    $display("Finished with errors");
    $finish;
  end

  initial begin
    int    lat;
    oprd_t a;
    oprd_t b;
    clk          = 1'b0;
    rst_n        = 1'b0;
    req          = 1'b0;
    operands     = '0;
    rng_state    = 32'hafbdda09;
    checks       = 0;
    value_errors = 0;
    proto_errors = 0;
    ack_prev     = 1'b0;
    corners[0]   = 32'h8000_0000;
    corners[1]   = 32'hffff_ffff;
    corners[2]   = 32'h0000_0001;
    corners[3]   = 32'h7fff_ffff;

    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;

    checks++;
    assert (ack === 1'b0 && result === '0) else begin
      value_errors++;
      $display("FAIL reset: expected ack 0 result %h, actual ack %b result %h",
               64'h0, ack, result);
    end

    for (int i = 0; i < NUM_RANDOM; i++) begin
      a = rand_word();
      b = rand_word();
      run_mul($sformatf("random_%0d", i), a, b, lat);
    end

    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 4; j++) begin
        run_mul($sformatf("corner_%0d_%0d", i, j), corners[i], corners[j], lat);
      end
    end

    // zero in a, in b, in both, and against the extreme values
    for (int i = 0; i < NUM_ZERO; i++) begin
      a = rand_word();
      b = rand_word();
      case (i)
        0: a = '0;
        1: b = '0;
        2: begin
          a = '0;
          b = '0;
        end
        3: begin
          a = '0;
          b = corners[0];
        end
        4: begin
          a = corners[3];
          b = '0;
        end
        default: begin
          a = corners[1];
          b = '0;
        end
      endcase
      run_mul($sformatf("zero_%0d", i), a, b, lat);
      assert (lat <= 3) else begin
        proto_errors++;
        $display("zero_%0d: early exit took %0d cycles to ack", i, lat);
      end
    end

    $display("checks: %0d, value errors: %0d, protocol errors: %0d",
             checks, value_errors, proto_errors);
    if (value_errors + proto_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- verilog.f
+incdir+include
rtl/mul_pkg.sv
rtl/booth_recoder.sv
rtl/oprd_sign.sv
rtl/zero_det.sv
rtl/booth_accum.sv
rtl/mul_ctrl.sv
rtl/mul_top.sv
verif/mul_tb.sv

//--- Bender.yml
package:
  name: booth_mul

sources:
  - include_dirs:
      - include
    files:
      - rtl/mul_pkg.sv
      - rtl/booth_recoder.sv
      - rtl/oprd_sign.sv
      - rtl/zero_det.sv
      - rtl/booth_accum.sv
      - rtl/mul_ctrl.sv
      - rtl/mul_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/mul_tb.sv
